// File: hw/uopPkg.sv
package uopPkg;

	typedef logic [7:0] opcodeT;
	typedef logic [6:0] flowAdrT;

	// Sequencing action carried by each micro-op
	// The eof group always ends a flow, the incEof flag group ends it conditionally
	typedef enum logic [3:0]
	{
		op          = 4'd0,
		inc         = 4'd1,
		eof         = 4'd2,
		incEof      = 4'd3,
		eofFu       = 4'd4,
		incEofFu    = 4'd5,
		incEofZ     = 4'd6,
		incEofNz    = 4'd7,
		incEofC     = 4'd8,
		updateFlags = 4'd9
	} pcActionT;

	typedef enum logic [5:0]
	{
		nop     = 6'd0,
		sma     = 6'd1,
		smw     = 6'd2,
		srm     = 6'd3,
		sx16r   = 6'd4,
		srx16   = 6'd5,
		addx16  = 6'd6,
		inc16   = 6'd7,
		dec16   = 6'd8,
		spc     = 6'd9,
		jcb     = 6'd10,
		bitTest = 6'd11,
		shr     = 6'd12,
		seti    = 6'd13,
		ceti    = 6'd14,
		jint    = 6'd15,
		xorx16  = 6'd16,
		z801bop = 6'd17
	} operationT;

	typedef enum logic [4:0]
	{
		none        = 5'd0,
		a           = 5'd1,
		b           = 5'd2,
		c           = 5'd3,
		h           = 5'd4,
		l           = 5'd5,
		x8          = 5'd6,
		x16         = 5'd7,
		pc          = 5'd8,
		pch         = 5'd9,
		sp          = 5'd10,
		hl          = 5'd11,
		idata       = 5'd12,
		intFlagsAdr = 5'd13
	} operandT;

	typedef struct packed
	{
		pcActionT  pcAction;
		operationT operation;
		operandT   operand;
	} uopT;

	typedef struct packed
	{
		opcodeT opcode;
		opcodeT cbByte;
		logic   zFlag;
		logic   cFlag;
	} instrReqT;

	////////////////////////////////////////////////////////////
	// Opcodes with a flow of their own
	////////////////////////////////////////////////////////////
	localparam opcodeT opNop    = 8'h00;
	localparam opcodeT opLdrnA  = 8'h3E;
	localparam opcodeT opIncrC  = 8'h0C;
	localparam opcodeT opJrnzN  = 8'h20;
	localparam opcodeT opJrzN   = 8'h28;
	localparam opcodeT opJrncN  = 8'h30;
	localparam opcodeT opPushBc = 8'hC5;
	localparam opcodeT opRet    = 8'hC9;
	localparam opcodeT opRetnz  = 8'hC0;
	localparam opcodeT opReti   = 8'hD9;
	localparam opcodeT opEi     = 8'hFB;
	localparam opcodeT opDi     = 8'hF3;
	localparam opcodeT opMapCb  = 8'hCB;

	// CB page
	localparam opcodeT cbBit7 = 8'h7C;
	localparam opcodeT cbSrlB = 8'h38;

	////////////////////////////////////////////////////////////
	// Flow start addresses in the micro-op ROM
	////////////////////////////////////////////////////////////
	localparam flowAdrT defaultFlowAdr = 7'd0;
	localparam flowAdrT nopFlowAdr     = 7'd2;
	localparam flowAdrT ldrnAFlowAdr   = 7'd3;
	localparam flowAdrT incrCFlowAdr   = 7'd6;
	localparam flowAdrT jrnzFlowAdr    = 7'd7;
	localparam flowAdrT jrzFlowAdr     = 7'd13;
	localparam flowAdrT jrncFlowAdr    = 7'd19;
	localparam flowAdrT pushBcFlowAdr  = 7'd25;
	localparam flowAdrT retFlowAdr     = 7'd31;
	localparam flowAdrT retnzFlowAdr   = 7'd40;
	localparam flowAdrT retiFlowAdr    = 7'd50;
	localparam flowAdrT eiFlowAdr      = 7'd60;
	localparam flowAdrT diFlowAdr      = 7'd61;
	localparam flowAdrT mapCbFlowAdr   = 7'd62;
	localparam flowAdrT bit7FlowAdr    = 7'd65;
	localparam flowAdrT srlBFlowAdr    = 7'd66;
	localparam flowAdrT intFlowAdr     = 7'd68;

endpackage

// File: hw/opcodeFlowLut.sv
`timescale 1ns/1ps

module opcodeFlowLut
(
	input  uopPkg::opcodeT  opcode,
	input  logic            cbPage,
	output uopPkg::flowAdrT flowAdr
);
	import uopPkg::*;

	always_comb
	begin
		flowAdr = defaultFlowAdr;
		if (cbPage)
		begin
			// Extended page reached through the CB prefix
			case (opcode)
				cbBit7:
					flowAdr = bit7FlowAdr;
				cbSrlB:
					flowAdr = srlBFlowAdr;
				default:
					flowAdr = defaultFlowAdr;
			endcase
		end
		else
		begin
			case (opcode)
				opNop:
					flowAdr = nopFlowAdr;
				opLdrnA:
					flowAdr = ldrnAFlowAdr;
				opIncrC:
					flowAdr = incrCFlowAdr;
				opJrnzN:
					flowAdr = jrnzFlowAdr;
				opJrzN:
					flowAdr = jrzFlowAdr;
				opJrncN:
					flowAdr = jrncFlowAdr;
				opPushBc:
					flowAdr = pushBcFlowAdr;
				opRet:
					flowAdr = retFlowAdr;
				opRetnz:
					flowAdr = retnzFlowAdr;
				opReti:
					flowAdr = retiFlowAdr;
				opEi:
					flowAdr = eiFlowAdr;
				opDi:
					flowAdr = diFlowAdr;
				opMapCb:
					flowAdr = mapCbFlowAdr;
				// Plain one byte ops share the default flow
				default:
					flowAdr = defaultFlowAdr;
			endcase
		end
	end

endmodule

// File: hw/uopRom.sv
`timescale 1ns/1ps

module uopRom
#(
	parameter int FLOW_DEPTH = 128
)
(
	input  uopPkg::flowAdrT adr,
	output uopPkg::uopT     uop
);
	import uopPkg::*;

	always_comb
	begin
		uop = '{op, nop, none};
		if (int'(adr) < FLOW_DEPTH)
		begin
			case (adr)
				// Default single byte flow
				defaultFlowAdr:         uop = '{updateFlags, z801bop, a};
				defaultFlowAdr + 7'd1:  uop = '{incEof, nop, none};
				// NOP
				nopFlowAdr:             uop = '{incEof, nop, none};
				// LDrn_a
				ldrnAFlowAdr:           uop = '{inc, sma, pc};
				ldrnAFlowAdr + 7'd1:    uop = '{inc, nop, none};
				ldrnAFlowAdr + 7'd2:    uop = '{eof, srm, a};
				// INCr_c
				incrCFlowAdr:           uop = '{incEofFu, inc16, c};

				////////////////////////////////////////////////////////////
				// Relative jumps
				////////////////////////////////////////////////////////////
				// JRNZn, skipped when Z is set
				jrnzFlowAdr:            uop = '{inc, sma, pc};
				jrnzFlowAdr + 7'd1:     uop = '{op, nop, none};
				jrnzFlowAdr + 7'd2:     uop = '{incEofZ, srm, x8};
				jrnzFlowAdr + 7'd3:     uop = '{op, sx16r, pc};
				jrnzFlowAdr + 7'd4:     uop = '{op, addx16, x8};
				jrnzFlowAdr + 7'd5:     uop = '{eof, spc, x16};
				// JRZn, skipped when Z is clear
				jrzFlowAdr:             uop = '{inc, sma, pc};
				jrzFlowAdr + 7'd1:      uop = '{op, nop, none};
				jrzFlowAdr + 7'd2:      uop = '{incEofNz, srm, x8};
				jrzFlowAdr + 7'd3:      uop = '{op, sx16r, pc};
				jrzFlowAdr + 7'd4:      uop = '{op, addx16, x8};
				jrzFlowAdr + 7'd5:      uop = '{eof, spc, x16};
				// JRNCn
				jrncFlowAdr:            uop = '{inc, sma, pc};
				jrncFlowAdr + 7'd1:     uop = '{incEofC, sx16r, pc};
				jrncFlowAdr + 7'd2:     uop = '{op, addx16, idata};
				jrncFlowAdr + 7'd3:     uop = '{op, inc16, x16};
				jrncFlowAdr + 7'd4:     uop = '{op, spc, x16};
				jrncFlowAdr + 7'd5:     uop = '{eof, nop, none};

				////////////////////////////////////////////////////////////
				// Stack flows
				////////////////////////////////////////////////////////////
				// PUSHBC
				pushBcFlowAdr:          uop = '{op, dec16, sp};
				pushBcFlowAdr + 7'd1:   uop = '{op, sma, sp};
				pushBcFlowAdr + 7'd2:   uop = '{op, smw, b};
				pushBcFlowAdr + 7'd3:   uop = '{op, dec16, sp};
				pushBcFlowAdr + 7'd4:   uop = '{op, smw, c};
				pushBcFlowAdr + 7'd5:   uop = '{incEof, sma, pc};
				// RET
				retFlowAdr:             uop = '{op, sma, sp};
				retFlowAdr + 7'd1:      uop = '{op, sx16r, hl};
				retFlowAdr + 7'd2:      uop = '{op, inc16, sp};
				retFlowAdr + 7'd3:      uop = '{op, srm, l};
				retFlowAdr + 7'd4:      uop = '{op, srm, h};
				retFlowAdr + 7'd5:      uop = '{op, spc, hl};
				retFlowAdr + 7'd6:      uop = '{op, srx16, hl};
				retFlowAdr + 7'd7:      uop = '{op, inc16, sp};
				retFlowAdr + 7'd8:      uop = '{eof, sma, pc};
				// RETNZ, a plain RET behind a Z test
				retnzFlowAdr:           uop = '{incEofZ, nop, none};
				retnzFlowAdr + 7'd1:    uop = '{op, sma, sp};
				retnzFlowAdr + 7'd2:    uop = '{op, sx16r, hl};
				retnzFlowAdr + 7'd3:    uop = '{op, inc16, sp};
				retnzFlowAdr + 7'd4:    uop = '{op, srm, l};
				retnzFlowAdr + 7'd5:    uop = '{op, srm, h};
				retnzFlowAdr + 7'd6:    uop = '{op, spc, hl};
				retnzFlowAdr + 7'd7:    uop = '{op, srx16, hl};
				retnzFlowAdr + 7'd8:    uop = '{op, inc16, sp};
				retnzFlowAdr + 7'd9:    uop = '{eof, sma, pc};
				// RETI
				retiFlowAdr:            uop = '{op, sma, sp};
				retiFlowAdr + 7'd1:     uop = '{op, sx16r, hl};
				retiFlowAdr + 7'd2:     uop = '{op, inc16, sp};
				retiFlowAdr + 7'd3:     uop = '{op, srm, l};
				retiFlowAdr + 7'd4:     uop = '{op, srm, h};
				retiFlowAdr + 7'd5:     uop = '{op, spc, hl};
				retiFlowAdr + 7'd6:     uop = '{op, srx16, hl};
				retiFlowAdr + 7'd7:     uop = '{op, inc16, sp};
				retiFlowAdr + 7'd8:     uop = '{op, sma, pc};
				retiFlowAdr + 7'd9:     uop = '{eof, seti, none};

				// Interrupt enable control
				eiFlowAdr:              uop = '{incEof, seti, none};
				diFlowAdr:              uop = '{incEof, ceti, none};

				////////////////////////////////////////////////////////////
				// CB prefix and extended ops
				////////////////////////////////////////////////////////////
				mapCbFlowAdr:           uop = '{inc, sma, pc};
				mapCbFlowAdr + 7'd1:    uop = '{op, nop, none};
				mapCbFlowAdr + 7'd2:    uop = '{inc, jcb, none};
				bit7FlowAdr:            uop = '{eofFu, bitTest, none};
				srlBFlowAdr:            uop = '{updateFlags, shr, none};
				srlBFlowAdr + 7'd1:     uop = '{eof, nop, none};

				// Interrupt entry, pushes pc and clears the pending flags
				intFlowAdr:             uop = '{inc, dec16, sp};
				intFlowAdr + 7'd1:      uop = '{op, sma, sp};
				intFlowAdr + 7'd2:      uop = '{op, smw, pch};
				intFlowAdr + 7'd3:      uop = '{op, dec16, sp};
				intFlowAdr + 7'd4:      uop = '{op, smw, pc};
				intFlowAdr + 7'd5:      uop = '{op, xorx16, x16};
				intFlowAdr + 7'd6:      uop = '{op, sma, intFlagsAdr};
				intFlowAdr + 7'd7:      uop = '{op, smw, x16};
				intFlowAdr + 7'd8:      uop = '{op, jint, none};
				intFlowAdr + 7'd9:      uop = '{eof, sma, pc};
				default:                uop = '{op, nop, none};
			endcase
		end
	end

endmodule

// File: hw/uopSequencer.sv
`timescale 1ns/1ps

module uopSequencer
(
	input  logic             clk,
	input  logic             rstN,
	input  uopPkg::instrReqT instrReq,
	input  logic             req,
	output logic             ack,
	input  logic             intTake,
	output uopPkg::opcodeT   lutOpcode,
	output logic             lutCbPage,
	input  uopPkg::flowAdrT  lutFlowAdr,
	output uopPkg::flowAdrT  romAdr,
	input  uopPkg::uopT      romUop,
	output uopPkg::uopT      uop,
	output logic             uopValid,
	input  logic             uopReady,
	output logic             uopLast
);
	import uopPkg::*;

	typedef enum logic [2:0]
	{
		idle,
		run,
		intRun,
		ackHigh,
		ackDrop
	} seqStateT;

	seqStateT state;
	instrReqT reqReg;
	flowAdrT  flowAdr;
	logic     flowEnd;
	logic     uopFire;
	logic     accept;

	// Interrupt entry wins over a pending request
	assign accept  = (state == idle) && !intTake && req;
	assign uopFire = uopValid && uopReady;

	// Main page lookup while idle, CB page of the latched byte afterwards
	assign lutOpcode = (state == idle) ? instrReq.opcode : reqReg.cbByte;
	assign lutCbPage = (state != idle);

	assign romAdr   = flowAdr;
	assign uop      = romUop;
	assign uopValid = (state == run) || (state == intRun);
	assign uopLast  = uopValid && flowEnd;
	assign ack      = (state == ackHigh);

	always_comb
	begin
		case (romUop.pcAction)
			eof, incEof, eofFu, incEofFu:
				flowEnd = 1'b1;
			incEofZ:
				flowEnd = reqReg.zFlag;
			incEofNz:
				flowEnd = !reqReg.zFlag;
			incEofC:
				flowEnd = reqReg.cFlag;
			default:
				flowEnd = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			reqReg <= instrReq;
	end

	////////////////////////////////////////////////////////////
	// Handshake and flow stepping
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= idle;
			flowAdr <= defaultFlowAdr;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (intTake)
					begin
						flowAdr <= intFlowAdr;
						state   <= intRun;
					end
					else if (accept)
					begin
						flowAdr <= lutFlowAdr;
						state   <= run;
					end
				end
				run, intRun:
				begin
					if (uopFire)
					begin
						// Interrupt flows finish without an ack
						if (flowEnd)
							state <= (state == run) ? ackHigh : idle;
						else if (romUop.operation == jcb)
							flowAdr <= lutFlowAdr;
						else
							flowAdr <= flowAdr + 7'd1;
					end
				end
				ackHigh:
				begin
					if (!req)
						state <= ackDrop;
				end
				ackDrop:
					state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

endmodule

// File: hw/intControl.sv
`timescale 1ns/1ps

module intControl
(
	input  logic        clk,
	input  logic        rstN,
	input  uopPkg::uopT uop,
	input  logic        uopFire,
	input  logic        intReq,
	output logic        intEnabled,
	output logic        intTake
);
	import uopPkg::*;

	// Interrupt master enable
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			intEnabled <= 1'b0;
		end
		else if (uopFire)
		begin
			case (uop.operation)
				seti:
					intEnabled <= 1'b1;
				// Entry masks further interrupts
				ceti, jint:
					intEnabled <= 1'b0;
				default:
					intEnabled <= intEnabled;
			endcase
		end
	end

	assign intTake = intReq && intEnabled;

endmodule

// File: hw/uopEngine.sv
`timescale 1ns/1ps

module uopEngine
#(
	parameter int FLOW_DEPTH = 128
)
(
	input  logic             clk,
	input  logic             rstN,
	input  uopPkg::instrReqT instrReq,
	input  logic             req,
	output logic             ack,
	output uopPkg::uopT      uop,
	output logic             uopValid,
	input  logic             uopReady,
	output logic             uopLast,
	input  logic             intReq,
	output logic             intEnabled
);
	import uopPkg::*;

	opcodeT  lutOpcode;
	logic    lutCbPage;
	flowAdrT lutFlowAdr;
	flowAdrT romAdr;
	uopT     romUop;
	logic    intTake;
	logic    uopFire;

	assign uopFire = uopValid && uopReady;

	opcodeFlowLut opcodeFlowLut_inst
	(
		.opcode  (lutOpcode),
		.cbPage  (lutCbPage),
		.flowAdr (lutFlowAdr)
	);

	uopRom
	#(
		.FLOW_DEPTH (FLOW_DEPTH)
	)
	uopRom_inst
	(
		.adr (romAdr),
		.uop (romUop)
	);

	uopSequencer uopSequencer_inst
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrReq   (instrReq),
		.req        (req),
		.ack        (ack),
		.intTake    (intTake),
		.lutOpcode  (lutOpcode),
		.lutCbPage  (lutCbPage),
		.lutFlowAdr (lutFlowAdr),
		.romAdr     (romAdr),
		.romUop     (romUop),
		.uop        (uop),
		.uopValid   (uopValid),
		.uopReady   (uopReady),
		.uopLast    (uopLast)
	);

	intControl intControl_inst
	(
		.clk        (clk),
		.rstN       (rstN),
		.uop        (uop),
		.uopFire    (uopFire),
		.intReq     (intReq),
		.intEnabled (intEnabled),
		.intTake    (intTake)
	);

endmodule

// File: verification/uopEngineTb.sv
`timescale 1ns/1ps

module uopEngineTb;
	import uopPkg::*;

	localparam int REC_LEN     = 18;
	localparam int MAX_RECORDS = 48;
	localparam int TIMEOUT     = 200;

	logic     clk;
	logic     rstN;
	instrReqT instrReq;
	logic     req;
	logic     ack;
	uopT      uop;
	logic     uopValid;
	logic     uopReady;
	logic     uopLast;
	logic     intReq;
	logic     intEnabled;

	// 8 header fields then 10 expected words per record
	logic [15:0] stim [0:MAX_RECORDS*REC_LEN-1];
	logic [31:0] lcgState;
	string       testName;

	uopEngine
	#(
		.FLOW_DEPTH (128)
	)
	uopEngine_inst
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrReq   (instrReq),
		.req        (req),
		.ack        (ack),
		.uop        (uop),
		.uopValid   (uopValid),
		.uopReady   (uopReady),
		.uopLast    (uopLast),
		.intReq     (intReq),
		.intEnabled (intEnabled)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		lcgNext = s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkEqual(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s, %s: expected %0h, actual %0h",
				testName, what, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic stopRun(input string reason);
		$display("ERROR in %s: %s", testName, reason);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	// Mode 0 keeps the sink ready, mode 1 draws a random bit
	task automatic driveReady(input logic [15:0] mode);
		if (mode == 16'd0)
		begin
			uopReady <= 1'b1;
		end
		else
		begin
			lcgState = lcgNext(lcgState);
			uopReady <= lcgState[16];
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stream and handshake helpers
	////////////////////////////////////////////////////////////
	task automatic collectStream(input int base, input int count, input logic [15:0] mode);
		int   idx;
		int   cycles;
		logic holding;
		uopT  heldUop;
		logic heldLast;
		idx = 0;
		cycles = 0;
		holding = 1'b0;
		heldUop = '0;
		heldLast = 1'b0;
		while (idx < count)
		begin
			@(posedge clk);
			driveReady(mode);
			@(negedge clk);
			// Words follow each other with no gap, starting one cycle after the start
			checkEqual("uopValid during flow", 1, uopValid);
			checkEqual("ack low while streaming", 0, ack);
			if (holding)
			begin
				checkEqual("uop held under back-pressure", heldUop, uop);
				checkEqual("uopLast held under back-pressure", heldLast, uopLast);
			end
			checkEqual($sformatf("word %0d", idx), stim[base+8+idx][14:0], uop);
			checkEqual($sformatf("uopLast on word %0d", idx), idx == count - 1, uopLast);
			if (uopReady)
			begin
				idx++;
				holding = 1'b0;
			end
			else
			begin
				holding = 1'b1;
				heldUop = uop;
				heldLast = uopLast;
			end
			cycles++;
			if (cycles > TIMEOUT)
				stopRun("timed out waiting for micro-op words");
		end
	endtask

	task automatic runInstruction(input int base);
		int       cycles;
		instrReqT nextReq;
		nextReq.opcode = stim[base][7:0];
		nextReq.cbByte = stim[base+1][7:0];
		nextReq.zFlag = stim[base+2][0];
		nextReq.cFlag = stim[base+3][0];
		@(posedge clk);
		instrReq <= nextReq;
		req <= 1'b1;
		driveReady(stim[base+5]);
		@(negedge clk);
		checkEqual("uopValid before accept", 0, uopValid);
		collectStream(base, stim[base+6], stim[base+5]);
		cycles = 0;
		while (!ack)
		begin
			@(negedge clk);
			checkEqual("uopValid low after last word", 0, uopValid);
			cycles++;
			if (cycles > TIMEOUT)
				stopRun("timed out waiting for ack to rise");
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		checkEqual("ack held until req drops", 1, ack);
		cycles = 0;
		while (ack)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				stopRun("timed out waiting for ack to drop");
		end
		checkEqual("intEnabled after instruction", stim[base+7][0], intEnabled);
	endtask

	task automatic runInterrupt(input int base);
		@(posedge clk);
		intReq <= 1'b1;
		driveReady(stim[base+5]);
		@(negedge clk);
		checkEqual("uopValid before interrupt entry", 0, uopValid);
		if (stim[base+6] != 16'd0)
			collectStream(base, stim[base+6], stim[base+5]);
		// Entry flow ends with no ack, and a masked request starts nothing
		repeat (6)
		begin
			@(negedge clk);
			checkEqual("no ack for interrupt", 0, ack);
			checkEqual("no words after interrupt", 0, uopValid);
		end
		@(posedge clk);
		intReq <= 1'b0;
		@(negedge clk);
		checkEqual("intEnabled after interrupt", stim[base+7][0], intEnabled);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int   recIdx;
		int   base;
		logic done;
		rstN = 1'b0;
		req = 1'b0;
		instrReq = '0;
		uopReady = 1'b0;
		intReq = 1'b0;
		lcgState = 32'ha45b_1c7b;
		testName = "reset";
		$readmemh("verification/flowInput.txt", stim);
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkEqual("ack after reset", 0, ack);
		checkEqual("uopValid after reset", 0, uopValid);
		checkEqual("uopLast after reset", 0, uopLast);
		checkEqual("intEnabled after reset", 0, intEnabled);
		recIdx = 0;
		done = 1'b0;
		while (!done)
		begin
			base = recIdx * REC_LEN;
			if (recIdx >= MAX_RECORDS)
				done = 1'b1;
			else if ($isunknown(stim[base]) || stim[base] == 16'hFFFF)
				done = 1'b1;
			else
			begin
				if (stim[base+4][0])
				begin
					testName = $sformatf("record %0d interrupt", recIdx);
					runInterrupt(base);
				end
				else
				begin
					testName = $sformatf("record %0d opcode %02h", recIdx, stim[base][7:0]);
					runInstruction(base);
				end
				recIdx++;
			end
		end
		if (recIdx == 0)
			stopRun("no records were read from the data file");
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: all.f
hw/uopPkg.sv
hw/opcodeFlowLut.sv
hw/uopRom.sv
hw/uopSequencer.sv
hw/intControl.sv
hw/uopEngine.sv
verification/uopEngineTb.sv

// File: Bender.yml
package:
  name: uop_engine

sources:
  - target: rtl
    files:
      - hw/uopPkg.sv
      - hw/opcodeFlowLut.sv
      - hw/uopRom.sv
      - hw/uopSequencer.sv
      - hw/intControl.sv
      - hw/uopEngine.sv

  - target: simulation
    files:
      - hw/uopPkg.sv
      - hw/opcodeFlowLut.sv
      - hw/uopRom.sv
      - hw/uopSequencer.sv
      - hw/intControl.sv
      - hw/uopEngine.sv
      - verification/uopEngineTb.sv

// File: verification/flowInput.txt
// opcode cbByte zFlag cFlag intReq readyMode count intEnabledAfter, then 10 word slots
// All hex; unused word slots are 0000, a lone FFFF ends the list
// Unconditional flows
00 00 0 0 0 0 01 0 1800 0000 0000 0000 0000 0000 0000 0000 0000 0000
3E 00 0 0 0 0 03 0 0828 0800 1061 0000 0000 0000 0000 0000 0000 0000
0C 00 0 0 0 0 01 0 28E3 0000 0000 0000 0000 0000 0000 0000 0000 0000
C5 00 0 0 0 0 06 0 010A 002A 0042 010A 0043 1828 0000 0000 0000 0000
C9 00 0 0 0 0 09 0 002A 008B 00EA 0065 0064 012B 00AB 00EA 1028 0000
F3 00 0 0 0 0 01 0 19C0 0000 0000 0000 0000 0000 0000 0000 0000 0000
// Conditional flows, short and long paths
20 00 1 0 0 0 03 0 0828 0000 3066 0000 0000 0000 0000 0000 0000 0000
20 00 0 0 0 0 06 0 0828 0000 3066 0088 00C6 1127 0000 0000 0000 0000
28 00 0 0 0 0 03 0 0828 0000 3866 0000 0000 0000 0000 0000 0000 0000
28 00 1 0 0 0 06 0 0828 0000 3866 0088 00C6 1127 0000 0000 0000 0000
30 00 0 1 0 0 02 0 0828 4088 0000 0000 0000 0000 0000 0000 0000 0000
30 00 0 0 0 0 06 0 0828 4088 00CC 00E7 0127 1000 0000 0000 0000 0000
C0 00 1 0 0 0 01 0 3000 0000 0000 0000 0000 0000 0000 0000 0000 0000
C0 00 0 0 0 0 0A 0 3000 002A 008B 00EA 0065 0064 012B 00AB 00EA 1028
// CB prefix and default flow
CB 7C 0 0 0 0 04 0 0828 0000 0940 2160 0000 0000 0000 0000 0000 0000
CB 38 0 0 0 0 05 0 0828 0000 0940 4980 1000 0000 0000 0000 0000 0000
CB 11 0 0 0 0 05 0 0828 0000 0940 4A21 1800 0000 0000 0000 0000 0000
47 00 0 0 0 0 02 0 4A21 1800 0000 0000 0000 0000 0000 0000 0000 0000
// Random back-pressure
C9 00 0 0 0 1 09 0 002A 008B 00EA 0065 0064 012B 00AB 00EA 1028 0000
20 00 0 0 0 1 06 0 0828 0000 3066 0088 00C6 1127 0000 0000 0000 0000
CB 38 0 0 0 1 05 0 0828 0000 0940 4980 1000 0000 0000 0000 0000 0000
C5 00 0 0 0 1 06 0 010A 002A 0042 010A 0043 1828 0000 0000 0000 0000
C0 00 0 0 0 1 0A 0 3000 002A 008B 00EA 0065 0064 012B 00AB 00EA 1028
// EI, then interrupt entry
FB 00 0 0 0 0 01 1 19A0 0000 0000 0000 0000 0000 0000 0000 0000 0000
00 00 0 0 1 0 0A 0 090A 002A 0049 010A 0048 0207 002D 0047 01E0 1028
// EI then DI, interrupt stays masked
FB 00 0 0 0 1 01 1 19A0 0000 0000 0000 0000 0000 0000 0000 0000 0000
F3 00 0 0 0 0 01 0 19C0 0000 0000 0000 0000 0000 0000 0000 0000 0000
00 00 0 0 1 0 00 0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// RETI enables again
D9 00 0 0 0 1 0A 1 002A 008B 00EA 0065 0064 012B 00AB 00EA 0028 11A0
00 00 0 0 1 1 0A 0 090A 002A 0049 010A 0048 0207 002D 0047 01E0 1028
FFFF
